// File: rtl/rv_core_cfg.svh
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// Data, address and instruction widths.
`define RV_XLEN         64
`define RV_ILEN         32
`define RV_REG_ADDR_W   5

// First fetch address.
`define RV_RESET_PC     64'h0000_0000_0000_0000

// --------------------
// Opcodes of the supported classes.
// --------------------
`define RV_OP_R         7'b0110011
`define RV_OP_I         7'b0010011
`define RV_OP_LOAD      7'b0000011
`define RV_OP_STORE     7'b0100011
`define RV_OP_BRANCH    7'b1100011
`define RV_OP_JAL       7'b1101111
`define RV_OP_LUI       7'b0110111

`endif

// File: rtl/rv_core_pkg.sv
`default_nettype none

`include "rv_core_cfg.svh"

package rv_core_pkg;

    typedef logic [`RV_XLEN-1:0]       xlen_t;
    typedef logic [`RV_ILEN-1:0]       instr_t;
    typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_J, IMM_U} imm_fmt_e;

    typedef enum logic [2:0] {
        ST_FETCH, ST_FETCH_WAIT, ST_DECODE, ST_EXECUTE,
        ST_MEM, ST_MEM_WAIT, ST_WRITEBACK, ST_TRAP
    } core_state_e;

    // --------------------
    // Mux select codes.
    // --------------------
    localparam logic [1:0] SRC_A_PC     = 2'd0;
    localparam logic [1:0] SRC_A_OLD_PC = 2'd1;
    localparam logic [1:0] SRC_A_REG    = 2'd2;

    localparam logic [1:0] SRC_B_REG    = 2'd0;
    localparam logic [1:0] SRC_B_IMM    = 2'd1;
    localparam logic [1:0] SRC_B_FOUR   = 2'd2;

    localparam logic [1:0] RES_ALU      = 2'd0;
    localparam logic [1:0] RES_ALU_REG  = 2'd1;
    localparam logic [1:0] RES_MDR      = 2'd2;

    typedef struct packed {
        logic  start;
        logic  write;
        xlen_t addr;
        xlen_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic       pc_en;
        logic       old_pc_en;
        logic       ir_en;
        logic       reg_we;
        logic       maddr_en;
        logic       mem_start;
        logic       mem_write;
        logic       addr_mar;
        alu_op_e    alu_op;
        imm_fmt_e   imm_fmt;
        logic [1:0] src_a_sel;
        logic [1:0] src_b_sel;
        logic [1:0] result_sel;
    } ctrl_t;

endpackage

`default_nettype wire

// File: rtl/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu
    import rv_core_pkg::*;
(
    input  alu_op_e i_op,
    input  xlen_t   i_src_1,
    input  xlen_t   i_src_2,
    output xlen_t   o_result,
    output logic    o_zero,
    output logic    o_less
);

    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = $signed(i_src_1) < $signed(i_src_2);
    assign lt_unsigned = i_src_1 < i_src_2;

    always_comb begin
        case (i_op)
            ALU_SUB:  o_result = i_src_1 - i_src_2;
            ALU_AND:  o_result = i_src_1 & i_src_2;
            ALU_OR:   o_result = i_src_1 | i_src_2;
            ALU_XOR:  o_result = i_src_1 ^ i_src_2;
            ALU_SLT:  o_result = xlen_t'(lt_signed);
            ALU_SLTU: o_result = xlen_t'(lt_unsigned);
            ALU_PASS_B: o_result = i_src_2;
            default:  o_result = i_src_1 + i_src_2;
        endcase
    end

    // Flags.
    assign o_zero = (o_result == '0);
    assign o_less = (i_op == ALU_SLTU) ? lt_unsigned : lt_signed;

endmodule

`default_nettype wire

// File: rtl/rv_imm_extend.sv
`timescale 1ns/1ps
`default_nettype none

module rv_imm_extend
    import rv_core_pkg::*;
(
    input  imm_fmt_e i_fmt,
    input  instr_t   i_instr,
    output xlen_t    o_imm
);

    logic signed [31:0] imm32;

    // Fields reassembled and signed at 32 bits first.
    always_comb begin
        case (i_fmt)
            IMM_S: imm32 = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
            IMM_B: imm32 = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25],
                            i_instr[11:8], 1'b0};
            IMM_J: imm32 = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20],
                            i_instr[30:21], 1'b0};
            IMM_U: imm32 = {i_instr[31:12], 12'b0};
            default: imm32 = {{20{i_instr[31]}}, i_instr[31:20]};
        endcase
    end

    // Sign extension to the full word.
    assign o_imm = xlen_t'(imm32);

endmodule

`default_nettype wire

// File: rtl/rv_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_reg_file
    import rv_core_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_we,
    input  reg_addr_t i_raddr_1,
    input  reg_addr_t i_raddr_2,
    input  reg_addr_t i_waddr,
    input  xlen_t     i_wdata,
    output xlen_t     o_rdata_1,
    output xlen_t     o_rdata_2
);

    xlen_t regs [2**`RV_REG_ADDR_W];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 2**`RV_REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_waddr != '0)) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // x0 never written, so it reads as zero.
    assign o_rdata_1 = regs[i_raddr_1];
    assign o_rdata_2 = regs[i_raddr_2];

endmodule

`default_nettype wire

// File: rtl/rv_datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_datapath
    import rv_core_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  ctrl_t    i_ctrl,
    input  logic     i_mem_done,
    input  xlen_t    i_mem_rdata,
    output instr_t   o_instr,
    output logic     o_zero,
    output logic     o_less,
    output mem_req_t o_mem_req
);

    xlen_t  pc_q;
    xlen_t  old_pc_q;
    instr_t ir_q;
    xlen_t  src_a_q;
    xlen_t  src_b_q;
    xlen_t  alu_q;
    xlen_t  maddr_q;
    xlen_t  mdr_q;
    instr_t fetch_word;
    xlen_t  rdata_1;
    xlen_t  rdata_2;
    xlen_t  imm;
    xlen_t  alu_a;
    xlen_t  alu_b;
    xlen_t  alu_y;
    xlen_t  result;

    // Instruction half of the fetched doubleword.
    assign fetch_word = pc_q[2] ? i_mem_rdata[`RV_XLEN-1 -: `RV_ILEN]
                                : i_mem_rdata[`RV_ILEN-1:0];
    assign o_instr    = ir_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc_q     <= `RV_RESET_PC;
            old_pc_q <= '0;
            ir_q     <= '0;
        end else begin
            if (i_ctrl.pc_en) pc_q <= result;
            if (i_ctrl.old_pc_en) old_pc_q <= pc_q;
            if (i_ctrl.ir_en && i_mem_done) ir_q <= fetch_word;
        end
    end

    // Operand, result and memory data registers.
    always_ff @(posedge i_clk) begin
        src_a_q <= rdata_1;
        src_b_q <= rdata_2;
        alu_q   <= alu_y;
        if (i_ctrl.maddr_en) maddr_q <= result;
        if (i_mem_done && !i_ctrl.ir_en) mdr_q <= i_mem_rdata;
    end

    // --------------------
    // Operand and result muxes.
    // --------------------
    always_comb begin
        case (i_ctrl.src_a_sel)
            SRC_A_OLD_PC: alu_a = old_pc_q;
            SRC_A_REG:    alu_a = src_a_q;
            default:      alu_a = pc_q;
        endcase
        case (i_ctrl.src_b_sel)
            SRC_B_IMM:  alu_b = imm;
            SRC_B_FOUR: alu_b = xlen_t'(4);
            default:    alu_b = src_b_q;
        endcase
        case (i_ctrl.result_sel)
            RES_ALU_REG: result = alu_q;
            RES_MDR:     result = mdr_q;
            default:     result = alu_y;
        endcase
    end

    always_comb begin
        o_mem_req.start = i_ctrl.mem_start;
        o_mem_req.write = i_ctrl.mem_write;
        o_mem_req.addr  = i_ctrl.addr_mar ? maddr_q : {pc_q[`RV_XLEN-1:3], 3'b000};
        o_mem_req.wdata = src_b_q;
    end

    rv_reg_file u_reg_file (
        .i_clk     ( i_clk         ),
        .i_rst_n   ( i_rst_n       ),
        .i_we      ( i_ctrl.reg_we ),
        .i_raddr_1 ( ir_q[19:15]   ),
        .i_raddr_2 ( ir_q[24:20]   ),
        .i_waddr   ( ir_q[11:7]    ),
        .i_wdata   ( result        ),
        .o_rdata_1 ( rdata_1       ),
        .o_rdata_2 ( rdata_2       )
    );

    rv_alu u_alu (
        .i_op     ( i_ctrl.alu_op ),
        .i_src_1  ( alu_a         ),
        .i_src_2  ( alu_b         ),
        .o_result ( alu_y         ),
        .o_zero   ( o_zero        ),
        .o_less   ( o_less        )
    );

    rv_imm_extend u_imm_extend (
        .i_fmt   ( i_ctrl.imm_fmt ),
        .i_instr ( ir_q           ),
        .o_imm   ( imm            )
    );

endmodule

`default_nettype wire

// File: rtl/rv_control_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_control_fsm
    import rv_core_pkg::*;
(
    input  logic   i_clk,
    input  logic   i_rst_n,
    input  logic   i_mem_done,
    input  instr_t i_instr,
    input  logic   i_zero,
    input  logic   i_less,
    output ctrl_t  o_ctrl,
    output logic   o_illegal
);

    core_state_e state_q;
    core_state_e state_d;
    logic        start_q;
    logic        illegal_q;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic        known_op;
    logic        br_taken;
    alu_op_e     r_op;

    assign opcode    = i_instr[6:0];
    assign funct3    = i_instr[14:12];
    assign o_illegal = illegal_q;

    // Relational branches use the less flag, equality ones the zero flag.
    assign br_taken = (funct3[2] ? i_less : i_zero) ^ funct3[0];

    always_comb begin
        case (opcode)
            `RV_OP_R, `RV_OP_I, `RV_OP_LOAD, `RV_OP_STORE,
            `RV_OP_BRANCH, `RV_OP_JAL, `RV_OP_LUI: known_op = 1'b1;
            default:                               known_op = 1'b0;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  r_op = i_instr[30] ? ALU_SUB : ALU_ADD;
            3'b010:  r_op = ALU_SLT;
            3'b011:  r_op = ALU_SLTU;
            3'b100:  r_op = ALU_XOR;
            3'b110:  r_op = ALU_OR;
            3'b111:  r_op = ALU_AND;
            default: r_op = ALU_ADD;
        endcase
    end

    // --------------------
    // State register.
    // --------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q   <= ST_FETCH;
            start_q   <= 1'b0;
            illegal_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // One start pulse per fetch or mem state.
            start_q <= (state_q == ST_FETCH) || (state_q == ST_MEM);
            if (state_d == ST_TRAP) begin
                illegal_q <= 1'b1;
            end
        end
    end

    // --------------------
    // Next state and datapath controls.
    // --------------------
    always_comb begin
        state_d          = state_q;
        o_ctrl           = '0;
        o_ctrl.mem_start = start_q;
        o_ctrl.alu_op    = ALU_ADD;
        o_ctrl.imm_fmt   = IMM_I;
        case (state_q)
            ST_FETCH: state_d = ST_FETCH_WAIT;
            ST_FETCH_WAIT: begin
                // PC + 4 goes into the PC when the fetch completes.
                o_ctrl.ir_en      = 1'b1;
                o_ctrl.src_a_sel  = SRC_A_PC;
                o_ctrl.src_b_sel  = SRC_B_FOUR;
                o_ctrl.result_sel = RES_ALU;
                o_ctrl.pc_en      = i_mem_done;
                o_ctrl.old_pc_en  = i_mem_done;
                if (i_mem_done) begin
                    state_d = ST_DECODE;
                end
            end
            ST_DECODE: begin
                // Branch or jump target, kept in the ALU result register.
                o_ctrl.src_a_sel = SRC_A_OLD_PC;
                o_ctrl.src_b_sel = SRC_B_IMM;
                o_ctrl.imm_fmt   = (opcode == `RV_OP_JAL) ? IMM_J : IMM_B;
                state_d          = known_op ? ST_EXECUTE : ST_TRAP;
            end
            ST_EXECUTE: begin
                o_ctrl.src_a_sel = SRC_A_REG;
                state_d          = ST_WRITEBACK;
                case (opcode)
                    `RV_OP_R:  o_ctrl.alu_op = r_op;
                    `RV_OP_I:  o_ctrl.src_b_sel = SRC_B_IMM;
                    `RV_OP_LOAD, `RV_OP_STORE: begin
                        o_ctrl.src_b_sel  = SRC_B_IMM;
                        o_ctrl.imm_fmt    = (opcode == `RV_OP_STORE) ? IMM_S : IMM_I;
                        o_ctrl.result_sel = RES_ALU;
                        o_ctrl.maddr_en   = 1'b1;
                        state_d           = ST_MEM;
                    end
                    `RV_OP_BRANCH: begin
                        if (funct3[2]) begin
                            o_ctrl.alu_op = funct3[1] ? ALU_SLTU : ALU_SLT;
                        end else begin
                            o_ctrl.alu_op = ALU_SUB;
                        end
                        o_ctrl.result_sel = RES_ALU_REG;
                        o_ctrl.pc_en      = br_taken;
                        state_d           = ST_FETCH;
                    end
                    `RV_OP_JAL: begin
                        // Target from decode into PC, link value computed now.
                        o_ctrl.src_a_sel  = SRC_A_OLD_PC;
                        o_ctrl.src_b_sel  = SRC_B_FOUR;
                        o_ctrl.result_sel = RES_ALU_REG;
                        o_ctrl.pc_en      = 1'b1;
                    end
                    `RV_OP_LUI: begin
                        o_ctrl.src_b_sel = SRC_B_IMM;
                        o_ctrl.imm_fmt   = IMM_U;
                        o_ctrl.alu_op    = ALU_PASS_B;
                    end
                    default: state_d = ST_TRAP;
                endcase
            end
            ST_MEM: begin
                o_ctrl.addr_mar  = 1'b1;
                o_ctrl.mem_write = (opcode == `RV_OP_STORE);
                state_d          = ST_MEM_WAIT;
            end
            ST_MEM_WAIT: begin
                o_ctrl.addr_mar  = 1'b1;
                o_ctrl.mem_write = (opcode == `RV_OP_STORE);
                if (i_mem_done) begin
                    state_d = (opcode == `RV_OP_STORE) ? ST_FETCH : ST_WRITEBACK;
                end
            end
            ST_WRITEBACK: begin
                o_ctrl.reg_we     = 1'b1;
                o_ctrl.result_sel = (opcode == `RV_OP_LOAD) ? RES_MDR : RES_ALU_REG;
                state_d           = ST_FETCH;
            end
            default: state_d = ST_TRAP;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_top
    import rv_core_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_mem_done,
    input  xlen_t    i_mem_rdata,
    output mem_req_t o_mem_req,
    output logic     o_illegal
);

    ctrl_t  ctrl;
    instr_t instr;
    logic   alu_zero;
    logic   alu_less;

    // --------------------
    // Control FSM.
    // --------------------
    rv_control_fsm u_control_fsm (
        .i_clk      ( i_clk      ),
        .i_rst_n    ( i_rst_n    ),
        .i_mem_done ( i_mem_done ),
        .i_instr    ( instr      ),
        .i_zero     ( alu_zero   ),
        .i_less     ( alu_less   ),
        .o_ctrl     ( ctrl       ),
        .o_illegal  ( o_illegal  )
    );

    // --------------------
    // Datapath.
    // --------------------
    rv_datapath u_datapath (
        .i_clk       ( i_clk       ),
        .i_rst_n     ( i_rst_n     ),
        .i_ctrl      ( ctrl        ),
        .i_mem_done  ( i_mem_done  ),
        .i_mem_rdata ( i_mem_rdata ),
        .o_instr     ( instr       ),
        .o_zero      ( alu_zero    ),
        .o_less      ( alu_less    ),
        .o_mem_req   ( o_mem_req   )
    );

endmodule

`default_nettype wire

// File: sim/rv_core_assert.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_assert
    import rv_core_pkg::*;
(
    input wire logic     i_clk,
    input wire logic     i_rst_n,
    input wire logic     i_mem_done,
    input wire mem_req_t i_mem_req
);

    logic pending;

    // Request outstanding between start and done.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pending <= 1'b0;
        end else if (i_mem_req.start) begin
            pending <= 1'b1;
        end else if (i_mem_done) begin
            pending <= 1'b0;
        end
    end

    start_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_mem_req.start |=> !i_mem_req.start)
        else $error("Memory start held longer than one cycle");

    req_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_mem_req.start || pending) && !i_mem_done
        |=> $stable(i_mem_req.addr) && $stable(i_mem_req.write))
        else $error("Memory address or write bit changed before done");

    no_start_pending: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        pending |-> !i_mem_req.start)
        else $error("New memory start while a request is outstanding");

endmodule

bind rv_core_top rv_core_assert u_assert (
    .i_clk      ( i_clk      ),
    .i_rst_n    ( i_rst_n    ),
    .i_mem_done ( i_mem_done ),
    .i_mem_req  ( o_mem_req  )
);

`default_nettype wire

// File: sim/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_cfg.svh"

module tb_rv_core
    import rv_core_pkg::*;
;

    localparam int NUM_ROWS     = 13;
    localparam int PROG_LEN     = 7;
    localparam int MEM_WORDS    = 128;
    localparam int RESET_CYCLES = 10;
    // Fetch, decode, execute, mem and writeback plus two waits of five cycles.
    localparam int MAX_CPI      = 15;
    localparam int TEST_CYCLES  = PROG_LEN * MAX_CPI * 2 + RESET_CYCLES + 4;
    localparam int CYCLE_LIMIT  = NUM_ROWS * TEST_CYCLES;
    localparam xlen_t RES_ADDR  = 64'h200;
    localparam xlen_t LD_ADDR   = 64'h100;
    localparam xlen_t LD_DATA   = 64'h0123_4567_89ab_cdef;

    logic     i_clk;
    logic     i_rst_n;
    logic     i_mem_done;
    xlen_t    i_mem_rdata;
    mem_req_t o_mem_req;
    logic     o_illegal;

    // Test table.
    string  names [NUM_ROWS];
    xlen_t  expect_val [NUM_ROWS];
    logic   expect_ill [NUM_ROWS];
    instr_t prog [NUM_ROWS][PROG_LEN];
    int     row_count;

    xlen_t    mem [MEM_WORDS];
    mem_req_t req;
    logic     busy;
    int       wait_cnt;
    logic     stored;
    xlen_t    store_val;
    int       cur_row;
    string    cur_name;
    int       cycles;
    int       errors;
    int       seed;
    logic     row_ok;

    rv_core_top u_dut (
        .i_clk       ( i_clk       ),
        .i_rst_n     ( i_rst_n     ),
        .i_mem_done  ( i_mem_done  ),
        .i_mem_rdata ( i_mem_rdata ),
        .o_mem_req   ( o_mem_req   ),
        .o_illegal   ( o_illegal   )
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    // --------------------
    // Instruction encoders.
    // --------------------
    function automatic instr_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                      input reg_addr_t rs1, input logic [2:0] f3,
                                      input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, `RV_OP_R};
    endfunction

    function automatic instr_t i_type(input int imm, input reg_addr_t rs1,
                                      input logic [2:0] f3, input reg_addr_t rd,
                                      input logic [6:0] op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic instr_t s_type(input int imm, input reg_addr_t rs2,
                                      input reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], `RV_OP_STORE};
    endfunction

    function automatic instr_t b_type(input int off, input reg_addr_t rs2,
                                      input reg_addr_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OP_BRANCH};
    endfunction

    function automatic instr_t j_type(input int off, input reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL};
    endfunction

    function automatic instr_t u_type(input logic [19:0] imm, input reg_addr_t rd);
        return {imm, rd, `RV_OP_LUI};
    endfunction

    // Every program ends with SD x3 to the result address and a self-loop.
    task automatic add_row(input string name, input xlen_t exp, input logic ill,
                           input instr_t p0, input instr_t p1, input instr_t p2,
                           input instr_t p3, input instr_t p4);
        names[row_count]      = name;
        expect_val[row_count] = exp;
        expect_ill[row_count] = ill;
        prog[row_count][0]    = p0;
        prog[row_count][1]    = p1;
        prog[row_count][2]    = p2;
        prog[row_count][3]    = p3;
        prog[row_count][4]    = p4;
        prog[row_count][5]    = s_type(int'(RES_ADDR), 5'd3, 5'd0);
        prog[row_count][6]    = j_type(0, 5'd0);
        row_count++;
    endtask

    task automatic fill_table();
        xlen_t  a;
        xlen_t  b;
        instr_t nop;
        instr_t ld_a;
        instr_t ld_b;
        a         = 64'd1443;
        b         = xlen_t'(-241);
        nop       = i_type(0, 5'd0, 3'b000, 5'd0, `RV_OP_I);
        ld_a      = i_type(1443, 5'd0, 3'b000, 5'd1, `RV_OP_I);
        ld_b      = i_type(-241, 5'd0, 3'b000, 5'd2, `RV_OP_I);
        row_count = 0;
        add_row("addi_add", xlen_t'(100) + xlen_t'(-300), 1'b0,
                i_type(100, 5'd0, 3'b000, 5'd1, `RV_OP_I),
                i_type(-300, 5'd0, 3'b000, 5'd2, `RV_OP_I),
                r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), nop, nop);
        add_row("sub", a - b, 1'b0, ld_a, ld_b,
                r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd3), nop, nop);
        add_row("and", a & b, 1'b0, ld_a, ld_b,
                r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd3), nop, nop);
        add_row("or", a | b, 1'b0, ld_a, ld_b,
                r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd3), nop, nop);
        add_row("xor", a ^ b, 1'b0, ld_a, ld_b,
                r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd3), nop, nop);
        // Signed -241 is below 1443, unsigned it is far above.
        add_row("slt", 64'd1, 1'b0, ld_a, ld_b,
                r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd3), nop, nop);
        add_row("sltu", 64'd0, 1'b0, ld_a, ld_b,
                r_type(7'h00, 5'd1, 5'd2, 3'b011, 5'd3), nop, nop);
        add_row("ld_copy", LD_DATA, 1'b0,
                i_type(int'(LD_ADDR), 5'd0, 3'b011, 5'd3, `RV_OP_LOAD), nop, nop, nop, nop);
        add_row("lui", xlen_t'($signed({20'habcde, 12'h000})), 1'b0,
                u_type(20'habcde, 5'd3), nop, nop, nop, nop);
        // A taken branch skips the marker, so 7 stays.
        add_row("beq_taken", 64'd7, 1'b0,
                i_type(7, 5'd0, 3'b000, 5'd3, `RV_OP_I), b_type(8, 5'd0, 5'd0, 3'b000),
                i_type(9, 5'd0, 3'b000, 5'd3, `RV_OP_I), nop, nop);
        add_row("bne_not_taken", 64'd9, 1'b0,
                i_type(7, 5'd0, 3'b000, 5'd3, `RV_OP_I), b_type(8, 5'd0, 5'd0, 3'b001),
                i_type(9, 5'd0, 3'b000, 5'd3, `RV_OP_I), nop, nop);
        // JAL at byte 4 jumps over the marker and links 4 + 4.
        add_row("jal_link", 64'd4 + 64'd4, 1'b0, nop, j_type(8, 5'd3),
                i_type(9, 5'd0, 3'b000, 5'd3, `RV_OP_I), nop, nop);
        add_row("illegal", '0, 1'b1, i_type(5, 5'd0, 3'b000, 5'd3, `RV_OP_I),
                32'h0000_007f, nop, nop, nop);
    endtask

    // --------------------
    // Memory model.
    // --------------------
    always @(negedge i_clk) begin
        if (!i_rst_n) begin
            busy       = 1'b0;
            stored     = 1'b0;
            i_mem_done = 1'b0;
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] = {32'(i) ^ 32'ha5a5_0f0f, ~32'(i)};
            end
            mem[LD_ADDR[9:3]] = LD_DATA;
            for (int k = 0; k < PROG_LEN; k++) begin
                if (k % 2 == 1) mem[k / 2][63:32] = prog[cur_row][k];
                else mem[k / 2][31:0] = prog[cur_row][k];
            end
        end else begin
            i_mem_done = 1'b0;
            if (busy) begin
                wait_cnt--;
                if (wait_cnt == 0) begin
                    busy       = 1'b0;
                    i_mem_done = 1'b1;
                    if (req.write) begin
                        mem[req.addr[9:3]] = req.wdata;
                        if (req.addr == RES_ADDR) begin
                            stored    = 1'b1;
                            store_val = req.wdata;
                        end
                    end else begin
                        i_mem_rdata = mem[req.addr[9:3]];
                    end
                end
            end else if (o_mem_req.start) begin
                busy     = 1'b1;
                req      = o_mem_req;
                wait_cnt = 1 + 32'($unsigned($random(seed)) % 4);
            end
        end
    end

    always @(posedge i_clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: test %s hung after %0d cycles in total", cur_name, cycles);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        seed        = 32'hd1d60983;
        i_rst_n     = 1'b0;
        i_mem_done  = 1'b0;
        i_mem_rdata = '0;
        cycles      = 0;
        errors      = 0;
        cur_row     = 0;
        cur_name    = "reset";
        fill_table();
        for (int r = 0; r < NUM_ROWS; r++) begin
            cur_row  = r;
            cur_name = names[r];
            row_ok   = 1'b1;
            @(negedge i_clk);
            i_rst_n = 1'b0;
            repeat (RESET_CYCLES) @(negedge i_clk);
            i_rst_n = 1'b1;
            while (!stored && !(expect_ill[r] && o_illegal)) @(posedge i_clk);
            if (expect_ill[r]) begin
                assert (o_illegal) else begin
                    $display("Test %s: illegal flag did not rise", names[r]);
                    row_ok = 1'b0;
                end
                repeat (PROG_LEN * MAX_CPI) @(posedge i_clk);
                assert (!stored) else begin
                    $display("Test %s: store seen after the illegal opcode", names[r]);
                    row_ok = 1'b0;
                end
            end else begin
                assert (!o_illegal) else begin
                    $display("Test %s: illegal flag raised on a legal program", names[r]);
                    row_ok = 1'b0;
                end
                assert (store_val == expect_val[r]) else begin
                    $display("ERR %s: expected %h, actual %h",
                             names[r], expect_val[r], store_val);
                    row_ok = 1'b0;
                end
            end
            if (!row_ok) errors++;
            $display("%-14s %s", names[r], row_ok ? "ok" : "mismatch");
        end
        $display("%0d tests run, %0d with errors", NUM_ROWS, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+rtl
rtl/rv_core_pkg.sv
rtl/rv_alu.sv
rtl/rv_imm_extend.sv
rtl/rv_reg_file.sv
rtl/rv_datapath.sv
rtl/rv_control_fsm.sv
rtl/rv_core_top.sv
sim/rv_core_assert.sv
sim/tb_rv_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_rv_core -o Vtb_rv_core
if [ $? -ne 0 ]; then
    echo "Compilation failed"
    exit 1
fi

./obj_dir/Vtb_rv_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    exit 1
fi
exit 0
